/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam int data_width = 32;
  localparam int reg_count  = 32;
  localparam int reg_bits   = 5;

  // word addressed memories
  localparam int imem_depth = 256;
  localparam int imem_bits  = 8;
  localparam int dmem_depth = 256;
  localparam int dmem_bits  = 8;

  // instruction fields
  localparam int op_msb    = 31;
  localparam int op_lsb    = 26;
  localparam int rs_msb    = 25;
  localparam int rs_lsb    = 21;
  localparam int rt_msb    = 20;
  localparam int rt_lsb    = 16;
  localparam int rd_msb    = 15;
  localparam int rd_lsb    = 11;
  localparam int shamt_msb = 10;
  localparam int shamt_lsb = 6;
  localparam int imm_msb   = 15;
  localparam int imm_lsb   = 0;

  // opcode alone selects the operation
  typedef enum logic [5:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_slt  = 6'd5,
    op_sll  = 6'd6,
    op_srl  = 6'd7,
    op_addi = 6'd8,
    op_lw   = 6'd9,
    op_sw   = 6'd10,
    op_beq  = 6'd11,
    op_bne  = 6'd12,
    op_j    = 6'd13,
    op_halt = 6'd14
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_sll, alu_srl, alu_pass_b
  } alu_op_t;

  typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_t;

endpackage

`default_nettype wire

/* rtl/fetch_stage.sv */
`default_nettype none

module fetch_stage (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            run,
  input  wire                            imem_we,
  input  wire [cpu_pkg::imem_bits-1:0]   imem_addr,
  input  wire [cpu_pkg::data_width-1:0]  imem_wdata,
  input  wire                            stall,
  input  wire                            halt_seen,
  input  wire                            flush,
  input  wire [cpu_pkg::imem_bits-1:0]   target,
  output logic                           if_valid,
  output logic [cpu_pkg::data_width-1:0] if_instr,
  output logic [cpu_pkg::imem_bits-1:0]  if_pc
);

  import cpu_pkg::*;

  logic [imem_bits-1:0]  pc;
  logic                  stopped;
  logic [data_width-1:0] imem [imem_depth];

  // pc and IF/ID valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc       <= '0;
      stopped  <= 1'b0;
      if_valid <= 1'b0;
    end else if (flush) begin
      // squash the slot being fetched, restart at target
      pc       <= target;
      if_valid <= 1'b0;
    end else if (halt_seen) begin
      stopped  <= 1'b1;
      if_valid <= 1'b0;
    end else if (stall) begin
      pc       <= pc;
      if_valid <= if_valid;
    end else if (run && !stopped) begin
      pc       <= pc + 1'b1;
      if_valid <= 1'b1;
    end else begin
      if_valid <= 1'b0;
    end
  end

  // instruction memory with load port
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  // IF/ID payload holds on stall
  always_ff @(posedge clk) begin
    if (!stall) begin
      if_instr <= imem[pc];
      if_pc    <= pc;
    end
  end

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`default_nettype none

module decode_stage (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            if_valid,
  input  wire [cpu_pkg::data_width-1:0]  if_instr,
  input  wire [cpu_pkg::imem_bits-1:0]   if_pc,
  input  wire                            flush,
  input  wire                            wb_we,
  input  wire [cpu_pkg::reg_bits-1:0]    wb_reg,
  input  wire [cpu_pkg::data_width-1:0]  wb_data,
  output logic                           stall,
  output logic                           halt_seen,
  output logic                           id_valid,
  output cpu_pkg::opcode_t               id_op,
  output cpu_pkg::alu_op_t               id_alu_op,
  output logic [cpu_pkg::reg_bits-1:0]   id_rs,
  output logic [cpu_pkg::reg_bits-1:0]   id_rt,
  output logic [cpu_pkg::reg_bits-1:0]   id_dst,
  output logic [cpu_pkg::data_width-1:0] id_a,
  output logic [cpu_pkg::data_width-1:0] id_b,
  output logic [cpu_pkg::data_width-1:0] id_imm,
  output logic                           id_use_imm,
  output logic                           id_mem_read,
  output logic                           id_mem_write,
  output logic                           id_reg_write,
  output logic                           id_branch_eq,
  output logic                           id_branch_ne,
  output logic                           id_jump,
  output logic                           id_halt
);

  import cpu_pkg::*;

  opcode_t               op;
  alu_op_t               alu_op;
  logic [reg_bits-1:0]   rs;
  logic [reg_bits-1:0]   rt;
  logic [reg_bits-1:0]   dst;
  logic [data_width-1:0] imm;
  logic [data_width-1:0] rs_val;
  logic [data_width-1:0] rt_val;
  logic use_imm, mem_read, mem_write, reg_write, branch_eq, branch_ne, jump, halt;
  logic [data_width-1:0] regs [reg_count];

  assign op   = opcode_t'(if_instr[op_msb:op_lsb]);
  assign rs   = if_instr[rs_msb:rs_lsb];
  assign rt   = if_instr[rt_msb:rt_lsb];
  assign imm  = {{(data_width-imm_msb-1){if_instr[imm_msb]}}, if_instr[imm_msb:imm_lsb]};

  always_comb begin
    alu_op    = alu_pass_b;
    dst       = if_instr[rd_msb:rd_lsb];
    use_imm   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    branch_eq = 1'b0;
    branch_ne = 1'b0;
    jump      = 1'b0;
    halt      = 1'b0;
    case (op)
      op_add:  begin alu_op = alu_add; reg_write = 1'b1; end
      op_sub:  begin alu_op = alu_sub; reg_write = 1'b1; end
      op_and:  begin alu_op = alu_and; reg_write = 1'b1; end
      op_or:   begin alu_op = alu_or;  reg_write = 1'b1; end
      op_slt:  begin alu_op = alu_slt; reg_write = 1'b1; end
      op_sll:  begin alu_op = alu_sll; reg_write = 1'b1; end
      op_srl:  begin alu_op = alu_srl; reg_write = 1'b1; end
      op_addi: begin alu_op = alu_add; use_imm = 1'b1; reg_write = 1'b1; dst = rt; end
      op_lw: begin
        alu_op    = alu_add;
        use_imm   = 1'b1;
        mem_read  = 1'b1;
        reg_write = 1'b1;
        dst       = rt;
      end
      op_sw:   begin alu_op = alu_add; use_imm = 1'b1; mem_write = 1'b1; end
      op_beq:  begin alu_op = alu_sub; branch_eq = 1'b1; end
      op_bne:  begin alu_op = alu_sub; branch_ne = 1'b1; end
      op_j:    jump = 1'b1;
      op_halt: halt = 1'b1;
      op_nop:  alu_op = alu_pass_b;
      default: alu_op = alu_pass_b;
    endcase
  end

  // load-use hazard against the load sitting in ID/EX
  assign stall = if_valid && id_valid && id_mem_read && id_dst != '0 &&
                 (id_dst == rs || id_dst == rt);
  assign halt_seen = if_valid && op == op_halt && !stall && !flush;

  // register file, write-through on read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we && wb_reg != '0) begin
      regs[wb_reg] <= wb_data;
    end
  end

  assign rs_val = (wb_we && wb_reg != '0 && wb_reg == rs) ? wb_data : regs[rs];
  assign rt_val = (wb_we && wb_reg != '0 && wb_reg == rt) ? wb_data : regs[rt];

  ////////////////////////////////////////////////////////////////////
  // ID/EX register

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_valid     <= 1'b0;
      id_mem_read  <= 1'b0;
      id_mem_write <= 1'b0;
      id_reg_write <= 1'b0;
      id_branch_eq <= 1'b0;
      id_branch_ne <= 1'b0;
      id_jump      <= 1'b0;
      id_halt      <= 1'b0;
    end else begin
      // bubble on stall, flush or an empty IF/ID
      id_valid     <= if_valid && !stall && !flush;
      id_mem_read  <= mem_read;
      id_mem_write <= mem_write;
      id_reg_write <= reg_write;
      id_branch_eq <= branch_eq;
      id_branch_ne <= branch_ne;
      id_jump      <= jump;
      id_halt      <= halt;
    end
  end

  always_ff @(posedge clk) begin
    id_op      <= op;
    id_alu_op  <= alu_op;
    id_rs      <= rs;
    id_rt      <= rt;
    id_dst     <= dst;
    id_a       <= rs_val;
    id_b       <= rt_val;
    id_imm     <= imm;
    id_use_imm <= use_imm;
  end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`default_nettype none

module execute_stage (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            id_valid,
  input  cpu_pkg::opcode_t               id_op,
  input  cpu_pkg::alu_op_t               id_alu_op,
  input  wire [cpu_pkg::reg_bits-1:0]    id_rs,
  input  wire [cpu_pkg::reg_bits-1:0]    id_rt,
  input  wire [cpu_pkg::reg_bits-1:0]    id_dst,
  input  wire [cpu_pkg::data_width-1:0]  id_a,
  input  wire [cpu_pkg::data_width-1:0]  id_b,
  input  wire [cpu_pkg::data_width-1:0]  id_imm,
  input  wire                            id_use_imm,
  input  wire                            id_mem_read,
  input  wire                            id_mem_write,
  input  wire                            id_reg_write,
  input  wire                            id_branch_eq,
  input  wire                            id_branch_ne,
  input  wire                            id_jump,
  input  wire                            id_halt,
  input  wire                            mem_reg_write,
  input  wire [cpu_pkg::reg_bits-1:0]    mem_dst,
  input  wire [cpu_pkg::data_width-1:0]  mem_result,
  input  wire                            wb_we,
  input  wire [cpu_pkg::reg_bits-1:0]    wb_reg,
  input  wire [cpu_pkg::data_width-1:0]  wb_data,
  output logic                           flush,
  output logic [cpu_pkg::imem_bits-1:0]  target,
  output logic                           ex_valid,
  output logic [cpu_pkg::data_width-1:0] ex_result,
  output logic [cpu_pkg::data_width-1:0] ex_store_data,
  output logic [cpu_pkg::reg_bits-1:0]   ex_dst,
  output logic                           ex_mem_read,
  output logic                           ex_mem_write,
  output logic                           ex_reg_write,
  output logic                           ex_halt
);

  import cpu_pkg::*;

  fwd_t                  fwd_a;
  fwd_t                  fwd_b;
  logic [data_width-1:0] a_val;
  logic [data_width-1:0] b_val;
  logic [data_width-1:0] b_opnd;
  logic [data_width-1:0] alu_y;
  logic                  equal;

  // EX/MEM is younger than writeback, so it is checked first
  function automatic fwd_t fwd_pick(input logic [reg_bits-1:0] src);
    if (mem_reg_write && mem_dst != '0 && mem_dst == src) begin
      return fwd_mem;
    end
    if (wb_we && wb_reg != '0 && wb_reg == src) begin
      return fwd_wb;
    end
    return fwd_none;
  endfunction

  function automatic logic [data_width-1:0] fwd_value(input fwd_t sel,
                                                      input logic [data_width-1:0] reg_val);
    case (sel)
      fwd_mem: return mem_result;
      fwd_wb:  return wb_data;
      default: return reg_val;
    endcase
  endfunction

  assign fwd_a = fwd_pick(id_rs);
  assign fwd_b = fwd_pick(id_rt);
  assign a_val = fwd_value(fwd_a, id_a);
  assign b_val = fwd_value(fwd_b, id_b);

  // shifts take their amount from the shamt field
  always_comb begin
    if (id_op == op_sll || id_op == op_srl) begin
      b_opnd = {{(data_width-shamt_msb+shamt_lsb-1){1'b0}}, id_imm[shamt_msb:shamt_lsb]};
    end else if (id_use_imm) begin
      b_opnd = id_imm;
    end else begin
      b_opnd = b_val;
    end
  end

  always_comb begin
    case (id_alu_op)
      alu_add: alu_y = a_val + b_opnd;
      alu_sub: alu_y = a_val - b_opnd;
      alu_and: alu_y = a_val & b_opnd;
      alu_or:  alu_y = a_val | b_opnd;
      alu_slt: alu_y = {{(data_width-1){1'b0}}, $signed(a_val) < $signed(b_opnd)};
      alu_sll: alu_y = a_val << b_opnd[shamt_msb-shamt_lsb:0];
      alu_srl: alu_y = a_val >> b_opnd[shamt_msb-shamt_lsb:0];
      default: alu_y = b_opnd;
    endcase
  end

  // branch resolution, absolute targets
  assign equal  = (a_val == b_val);
  assign flush  = id_valid && ((id_branch_eq && equal) || (id_branch_ne && !equal) || id_jump);
  assign target = id_imm[imem_bits-1:0];

  ////////////////////////////////////////////////////////////////////
  // EX/MEM register

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid     <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_halt      <= 1'b0;
    end else begin
      ex_valid     <= id_valid;
      ex_mem_read  <= id_mem_read;
      ex_mem_write <= id_mem_write;
      ex_reg_write <= id_reg_write;
      ex_halt      <= id_halt;
    end
  end

  always_ff @(posedge clk) begin
    ex_result     <= alu_y;
    ex_store_data <= b_val;
    ex_dst        <= id_dst;
  end

endmodule

`default_nettype wire

/* rtl/memory_stage.sv */
`default_nettype none

module memory_stage (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            ex_valid,
  input  wire [cpu_pkg::data_width-1:0]  ex_result,
  input  wire [cpu_pkg::data_width-1:0]  ex_store_data,
  input  wire [cpu_pkg::reg_bits-1:0]    ex_dst,
  input  wire                            ex_mem_read,
  input  wire                            ex_mem_write,
  input  wire                            ex_reg_write,
  input  wire                            ex_halt,
  output logic                           mem_reg_write,
  output logic [cpu_pkg::reg_bits-1:0]   mem_dst,
  output logic [cpu_pkg::data_width-1:0] mem_result,
  output logic                           wb_we,
  output logic [cpu_pkg::reg_bits-1:0]   wb_reg,
  output logic [cpu_pkg::data_width-1:0] wb_data,
  output logic                           wb_valid,
  output logic                           halted
);

  import cpu_pkg::*;

  logic [dmem_bits-1:0]  addr;
  logic [data_width-1:0] wb_load;
  logic [data_width-1:0] wb_alu;
  logic                  wb_sel_load;
  logic                  wb_halt;
  logic [data_width-1:0] dmem [dmem_depth];

  assign addr          = ex_result[dmem_bits-1:0];
  assign mem_reg_write = ex_valid && ex_reg_write;
  assign mem_dst       = ex_dst;
  assign mem_result    = ex_result;

  // data memory, read lands directly in MEM/WB
  always_ff @(posedge clk) begin
    if (ex_valid && ex_mem_write) begin
      dmem[addr] <= ex_store_data;
    end
    wb_load <= dmem[addr];
  end

  ////////////////////////////////////////////////////////////////////
  // MEM/WB register and writeback

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_we   <= 1'b0;
      wb_halt <= 1'b0;
      halted  <= 1'b0;
    end else begin
      wb_we   <= ex_valid && ex_reg_write;
      wb_halt <= ex_valid && ex_halt;
      // sticky until reset
      halted  <= halted || wb_halt;
    end
  end

  always_ff @(posedge clk) begin
    wb_alu      <= ex_result;
    wb_reg      <= ex_dst;
    wb_sel_load <= ex_mem_read;
  end

  assign wb_data  = wb_sel_load ? wb_load : wb_alu;
  // register 0 writes are dropped and stay off the trace
  assign wb_valid = wb_we && wb_reg != '0;

endmodule

`default_nettype wire

/* rtl/processor.sv */
`default_nettype none

module processor (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            run,
  input  wire                            imem_we,
  input  wire [cpu_pkg::imem_bits-1:0]   imem_addr,
  input  wire [cpu_pkg::data_width-1:0]  imem_wdata,
  output logic                           wb_valid,
  output logic [cpu_pkg::reg_bits-1:0]   wb_reg,
  output logic [cpu_pkg::data_width-1:0] wb_data,
  output logic                           halted
);

  import cpu_pkg::*;

  // IF/ID and fetch control
  logic                  if_valid;
  logic [data_width-1:0] if_instr;
  logic [imem_bits-1:0]  if_pc;
  logic                  stall;
  logic                  halt_seen;
  logic                  flush;
  logic [imem_bits-1:0]  target;

  // ID/EX
  logic                  id_valid;
  opcode_t               id_op;
  alu_op_t               id_alu_op;
  logic [reg_bits-1:0]   id_rs;
  logic [reg_bits-1:0]   id_rt;
  logic [reg_bits-1:0]   id_dst;
  logic [data_width-1:0] id_a;
  logic [data_width-1:0] id_b;
  logic [data_width-1:0] id_imm;
  logic id_use_imm, id_mem_read, id_mem_write, id_reg_write;
  logic id_branch_eq, id_branch_ne, id_jump, id_halt;

  // EX/MEM and forwarding paths
  logic                  ex_valid;
  logic [data_width-1:0] ex_result;
  logic [data_width-1:0] ex_store_data;
  logic [reg_bits-1:0]   ex_dst;
  logic ex_mem_read, ex_mem_write, ex_reg_write, ex_halt;
  logic                  mem_reg_write;
  logic [reg_bits-1:0]   mem_dst;
  logic [data_width-1:0] mem_result;
  logic                  wb_we;

  //////////////////////////////////////////////////////////////////////

  fetch_stage i_fetch (
    .clk(clk), .rst_n(rst_n), .run(run),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .stall(stall), .halt_seen(halt_seen), .flush(flush), .target(target),
    .if_valid(if_valid), .if_instr(if_instr), .if_pc(if_pc)
  );

  //////////////////////////////////////////////////////////////////////

  decode_stage i_decode (
    .clk(clk), .rst_n(rst_n),
    .if_valid(if_valid), .if_instr(if_instr), .if_pc(if_pc), .flush(flush),
    .wb_we(wb_we), .wb_reg(wb_reg), .wb_data(wb_data),
    .stall(stall), .halt_seen(halt_seen),
    .id_valid(id_valid), .id_op(id_op), .id_alu_op(id_alu_op),
    .id_rs(id_rs), .id_rt(id_rt), .id_dst(id_dst),
    .id_a(id_a), .id_b(id_b), .id_imm(id_imm), .id_use_imm(id_use_imm),
    .id_mem_read(id_mem_read), .id_mem_write(id_mem_write), .id_reg_write(id_reg_write),
    .id_branch_eq(id_branch_eq), .id_branch_ne(id_branch_ne),
    .id_jump(id_jump), .id_halt(id_halt)
  );

  execute_stage i_execute (
    .clk(clk), .rst_n(rst_n),
    .id_valid(id_valid), .id_op(id_op), .id_alu_op(id_alu_op),
    .id_rs(id_rs), .id_rt(id_rt), .id_dst(id_dst),
    .id_a(id_a), .id_b(id_b), .id_imm(id_imm), .id_use_imm(id_use_imm),
    .id_mem_read(id_mem_read), .id_mem_write(id_mem_write), .id_reg_write(id_reg_write),
    .id_branch_eq(id_branch_eq), .id_branch_ne(id_branch_ne),
    .id_jump(id_jump), .id_halt(id_halt),
    .mem_reg_write(mem_reg_write), .mem_dst(mem_dst), .mem_result(mem_result),
    .wb_we(wb_we), .wb_reg(wb_reg), .wb_data(wb_data),
    .flush(flush), .target(target),
    .ex_valid(ex_valid), .ex_result(ex_result), .ex_store_data(ex_store_data),
    .ex_dst(ex_dst), .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
    .ex_reg_write(ex_reg_write), .ex_halt(ex_halt)
  );

  //////////////////////////////////////////////////////////////////////

  memory_stage i_memory (
    .clk(clk), .rst_n(rst_n),
    .ex_valid(ex_valid), .ex_result(ex_result), .ex_store_data(ex_store_data),
    .ex_dst(ex_dst), .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
    .ex_reg_write(ex_reg_write), .ex_halt(ex_halt),
    .mem_reg_write(mem_reg_write), .mem_dst(mem_dst), .mem_result(mem_result),
    .wb_we(wb_we), .wb_reg(wb_reg), .wb_data(wb_data),
    .wb_valid(wb_valid), .halted(halted)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset low for 4 cycles, changed on the falling edge
  task automatic hold_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
  endtask

  initial begin
    rst_n = 1'b0;
  end

endmodule

`default_nettype wire

/* testbench/tb_checker.sv */
`default_nettype none

module tb_checker (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            wb_valid,
  input  wire [cpu_pkg::reg_bits-1:0]    wb_reg,
  input  wire [cpu_pkg::data_width-1:0]  wb_data,
  input  wire                            halted,
  output int                             errors
);

  timeunit 1ns;
  timeprecision 1ps;

  import cpu_pkg::*;

  logic [reg_bits-1:0]   exp_reg [$];
  logic [data_width-1:0] exp_val [$];
  logic                  halted_q;

  initial begin
    errors   = 0;
    halted_q = 1'b0;
  end

  task automatic push_expected(input logic [reg_bits-1:0] r, input logic [data_width-1:0] v);
    exp_reg.push_back(r);
    exp_val.push_back(v);
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n === 1'b1 && wb_valid === 1'b1) begin
      if (exp_reg.size() == 0) begin
        $display("write to r%0d at %0t ns arrived with no write expected", wb_reg, $time);
        errors++;
      end else begin
        if (wb_reg !== exp_reg[0]) begin
          $display("Error at %0t ns: wb_reg got %0d expected %0d", $time, wb_reg, exp_reg[0]);
          errors++;
        end
        if (wb_data !== exp_val[0]) begin
          $display("Error at %0t ns: wb_data got %h expected %h", $time, wb_data, exp_val[0]);
          errors++;
        end
        void'(exp_reg.pop_front());
        void'(exp_val.pop_front());
      end
    end
    // leftovers once the core says it is done
    if (halted === 1'b1 && !halted_q) begin
      if (exp_reg.size() != 0) begin
        $display("halt reached at %0t ns with %0d expected writes never seen",
                 $time, exp_reg.size());
        errors += exp_reg.size();
        exp_reg.delete();
        exp_val.delete();
      end
    end
    halted_q <= (halted === 1'b1);
  end

endmodule

`default_nettype wire

/* testbench/tb_processor.sv */
`default_nettype none

module tb_processor;

  timeunit 1ns;
  timeprecision 1ps;

  import cpu_pkg::*;

  logic                  clk;
  logic                  rst_n;
  logic                  run;
  logic                  imem_we;
  logic [imem_bits-1:0]  imem_addr;
  logic [data_width-1:0] imem_wdata;
  logic                  wb_valid;
  logic [reg_bits-1:0]   wb_reg;
  logic [data_width-1:0] wb_data;
  logic                  halted;
  int                    trace_errors;
  int                    seq_errors = 0;
  int                    cycles = 0;
  int                    limit = 0;
  logic [31:0]           lfsr = 32'hc2b;
  logic [31:0]           prog [$];
  logic [reg_bits-1:0]   exp_reg [$];
  logic [data_width-1:0] exp_val [$];

  tb_clock_gen i_clock_gen (.clk(clk), .rst_n(rst_n));

  processor i_processor (
    .clk(clk), .rst_n(rst_n), .run(run),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .halted(halted)
  );

  tb_checker i_checker (
    .clk(clk), .rst_n(rst_n), .wb_valid(wb_valid), .wb_reg(wb_reg),
    .wb_data(wb_data), .halted(halted), .errors(trace_errors)
  );

  // galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] r_form(opcode_t op, int rd, int rs, int rt, int sh);
    logic [31:0] w;
    w = '0;
    w[op_msb:op_lsb]       = op;
    w[rs_msb:rs_lsb]       = 5'(rs);
    w[rt_msb:rt_lsb]       = 5'(rt);
    w[rd_msb:rd_lsb]       = 5'(rd);
    w[shamt_msb:shamt_lsb] = 5'(sh);
    return w;
  endfunction

  function automatic logic [31:0] i_form(opcode_t op, int rt, int rs, int imm);
    logic [31:0] w;
    w = '0;
    w[op_msb:op_lsb]   = op;
    w[rs_msb:rs_lsb]   = 5'(rs);
    w[rt_msb:rt_lsb]   = 5'(rt);
    w[imm_msb:imm_lsb] = 16'(imm);
    return w;
  endfunction

  // in-order ISA model, one instruction per step
  function automatic void reference_run();
    logic [31:0] regs [32];
    logic [31:0] dmem [logic [7:0]];
    logic [7:0]  pc;
    logic [31:0] w, a, b, simm, res;
    opcode_t     op;
    int          rd, steps;
    logic        wr;
    exp_reg.delete();
    exp_val.delete();
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    pc = '0;
    for (steps = 0; steps < 1000; steps++) begin
      w    = (int'(pc) < prog.size()) ? prog[pc] : '0;
      op   = opcode_t'(w[op_msb:op_lsb]);
      a    = regs[w[rs_msb:rs_lsb]];
      b    = regs[w[rt_msb:rt_lsb]];
      simm = {{16{w[imm_msb]}}, w[imm_msb:imm_lsb]};
      rd   = int'(w[rd_msb:rd_lsb]);
      res  = '0;
      wr   = 1'b1;
      if (op == op_halt) begin
        break;
      end
      pc = pc + 8'd1;
      case (op)
        op_add:  res = a + b;
        op_sub:  res = a - b;
        op_and:  res = a & b;
        op_or:   res = a | b;
        op_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        op_sll:  res = a << w[shamt_msb:shamt_lsb];
        op_srl:  res = a >> w[shamt_msb:shamt_lsb];
        op_addi: begin res = a + simm; rd = int'(w[rt_msb:rt_lsb]); end
        op_lw: begin
          res = dmem[8'(a + simm)];
          rd  = int'(w[rt_msb:rt_lsb]);
        end
        op_sw: begin dmem[8'(a + simm)] = b; wr = 1'b0; end
        op_beq: begin wr = 1'b0; if (a == b) pc = w[7:0]; end
        op_bne: begin wr = 1'b0; if (a != b) pc = w[7:0]; end
        op_j:    begin wr = 1'b0; pc = w[7:0]; end
        default: wr = 1'b0;
      endcase
      if (wr && rd != 0) begin
        regs[rd] = res;
        exp_reg.push_back(5'(rd));
        exp_val.push_back(res);
      end
    end
  endfunction

  task automatic run_test(input string name);
    limit += 4 * prog.size() + 40;
    run     = 1'b0;
    imem_we = 1'b0;
    i_clock_gen.hold_reset();
    for (int i = 0; i < prog.size(); i++) begin
      @(negedge clk);
      imem_we    = 1'b1;
      imem_addr  = 8'(i);
      imem_wdata = prog[i];
    end
    @(negedge clk);
    imem_we = 1'b0;
    reference_run();
    // core stays idle while run is low
    repeat (5) begin
      @(negedge clk);
      if (halted !== 1'b0) begin
        $display("halted was not low while run was low in test %s", name);
        seq_errors++;
      end
    end
    run = 1'b1;
    // a write while idle meets an empty queue
    @(posedge clk);
    for (int i = 0; i < exp_reg.size(); i++) begin
      i_checker.push_expected(exp_reg[i], exp_val[i]);
    end
    while (halted !== 1'b1) begin
      @(negedge clk);
    end
    // late writes after halt are caught by the checker
    repeat (5) @(negedge clk);
    run = 1'b0;
    prog.delete();
  endtask

  // timeout
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: halted not seen within %0d cycles", limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    opcode_t alu_ops [7];
    logic [2:0] sel;
    alu_ops    = '{op_add, op_sub, op_and, op_or, op_slt, op_sll, op_srl};
    run        = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;

    ////////////////////////////////////////////////////////////////////
    // ALU and immediate
    prog = '{i_form(op_addi, 1, 0, 5), i_form(op_addi, 2, 0, -3),
             i_form(op_addi, 3, 0, 16'h1234), r_form(op_add, 4, 1, 3, 0),
             r_form(op_add, 0, 1, 2, 0), r_form(op_sub, 5, 1, 2, 0),
             r_form(op_and, 6, 2, 3, 0), r_form(op_or, 7, 1, 3, 0),
             r_form(op_slt, 8, 2, 1, 0), r_form(op_slt, 11, 1, 2, 0),
             r_form(op_sll, 9, 3, 0, 4), r_form(op_srl, 10, 2, 0, 28),
             r_form(op_halt, 0, 0, 0, 0)};
    run_test("alu");

    // forwarding from EX/MEM and from writeback
    prog = '{i_form(op_addi, 1, 0, 7), r_form(op_add, 2, 1, 1, 0),
             r_form(op_add, 3, 2, 1, 0), r_form(op_sub, 4, 3, 2, 0),
             r_form(op_nop, 0, 0, 0, 0), r_form(op_or, 5, 4, 1, 0),
             i_form(op_addi, 1, 1, 1), r_form(op_nop, 0, 0, 0, 0),
             r_form(op_add, 6, 1, 5, 0), r_form(op_halt, 0, 0, 0, 0)};
    run_test("forwarding");

    // store and load, with a load-use pair
    prog = '{i_form(op_addi, 1, 0, 100), i_form(op_addi, 2, 0, 16),
             i_form(op_sw, 1, 2, 0), i_form(op_addi, 3, 0, -77),
             i_form(op_sw, 3, 2, 1), i_form(op_lw, 4, 2, 0),
             i_form(op_lw, 5, 2, 1), r_form(op_add, 6, 5, 4, 0),
             i_form(op_lw, 7, 2, 0), i_form(op_sw, 7, 2, 2),
             i_form(op_lw, 8, 2, 2), r_form(op_halt, 0, 0, 0, 0)};
    run_test("load_store");

    // taken and not-taken branches, jump
    prog = '{i_form(op_addi, 1, 0, 3), i_form(op_addi, 2, 0, 3),
             i_form(op_beq, 2, 1, 5), i_form(op_addi, 10, 0, 1),
             i_form(op_addi, 11, 0, 1), i_form(op_bne, 2, 1, 8),
             i_form(op_addi, 3, 0, 1), i_form(op_j, 0, 0, 10),
             i_form(op_addi, 12, 0, 1), i_form(op_addi, 13, 0, 1),
             i_form(op_beq, 3, 1, 13), i_form(op_bne, 3, 1, 14),
             i_form(op_addi, 14, 0, 1), i_form(op_addi, 15, 0, 1),
             i_form(op_addi, 4, 0, 9), r_form(op_halt, 0, 0, 0, 0)};
    run_test("branch");

    // nothing behind halt retires
    prog = '{i_form(op_addi, 1, 0, 1), r_form(op_halt, 0, 0, 0, 0),
             i_form(op_addi, 2, 0, 2), i_form(op_addi, 3, 0, 3),
             i_form(op_addi, 4, 0, 4)};
    run_test("halt");

    // random straight-line ALU code
    for (int i = 0; i < 40; i++) begin
      sel = 3'(rand_bits(3));
      if (sel == 3'd7) begin
        prog.push_back(i_form(op_addi, int'(rand_bits(5)), int'(rand_bits(5)),
                              int'(rand_bits(16))));
      end else begin
        prog.push_back(r_form(alu_ops[sel], int'(rand_bits(5)), int'(rand_bits(5)),
                              int'(rand_bits(5)), int'(rand_bits(5))));
      end
    end
    prog.push_back(r_form(op_halt, 0, 0, 0, 0));
    run_test("random");

    $display("errors: trace %0d, sequence %0d", trace_errors, seq_errors);
    if (trace_errors == 0 && seq_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/processor.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_processor.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_processor
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
